// ==== burst_counter.sv ====
`include "cache_params.svh"

module burst_counter
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 step,
  output logic [`OFFSET_W-1:0] offset,
  output logic                 done
);

  localparam logic [`OFFSET_W-1:0] LAST = `OFFSET_W'(`LINE_WORDS - 1);

  assign done = step && (offset == LAST);

  // Word offset of the next word in the burst
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      offset <= '0;
    else if (start || done)
      offset <= '0;
    else if (step)
      offset <= offset + 1'b1;
  end

endmodule

// ==== cache_addr_pkg.sv ====
`include "cache_params.svh"

package cache_addr_pkg;

  // Byte address split into cache fields
  typedef struct packed {
    logic [`TAG_W-1:0]    tag;
    logic [`INDEX_W-1:0]  index;
    logic [`OFFSET_W-1:0] offset;
    logic [1:0]           byte_off;
  } addr_fields_t;

  // Same address word seen raw or by field
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t f;
  } addr_u;

  typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

  // 0 is most recently used
  typedef logic [$clog2(`CACHE_WAYS)-1:0] age_t;

endpackage

// ==== cache_bus_pkg.sv ====
package cache_bus_pkg;

  import cache_addr_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // CPU side
  ///////////////////////////////////////////////////////////////////////

  typedef struct packed {
    addr_u       addr;
    logic        write;  // 1 for store
    logic [31:0] wdata;
    logic [3:0]  be;     // Byte lane enables
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } cpu_rsp_t;

  ///////////////////////////////////////////////////////////////////////
  // Memory side
  ///////////////////////////////////////////////////////////////////////

  // Refill burst request
  typedef struct packed {
    logic [31:0] addr;  // Line address
    logic        rd_req;
  } mem_rd_t;

  // Write-back burst
  typedef struct packed {
    logic [31:0] addr;  // Victim line address
    logic [31:0] wdata;
    logic        wr_req;
  } mem_wr_t;

endpackage

// ==== cache_ctrl_fsm.sv ====
module cache_ctrl_fsm
(
  input  logic clk,
  input  logic rst,
  input  logic cpu_req,
  input  logic hit,
  input  logic victim_dirty,
  input  logic burst_done,
  output logic latch_req,
  output logic lookup,
  output logic wb_active,
  output logic fill_active,
  output logic install,
  output logic touch,
  output logic cpu_write_en,
  output logic cpu_ack
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    DONE
  } state_t;

  state_t state;
  state_t next_state;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
        if (cpu_req)
          next_state = LOOKUP;
      LOOKUP:
      begin
        if (hit)
          next_state = DONE;
        else if (victim_dirty)
          next_state = WRITEBACK;  // Flush victim first
        else
          next_state = REFILL;
      end
      WRITEBACK:
        if (burst_done)
          next_state = REFILL;
      REFILL:
        if (burst_done)
          next_state = LOOKUP;  // Retry now hits
      DONE:
        if (!cpu_req)
          next_state = IDLE;
      default:
        next_state = IDLE;
    endcase
  end

  ///////////////////////////////////////////////////////////////////////
  // Control outputs
  ///////////////////////////////////////////////////////////////////////

  assign latch_req   = (state == IDLE) && cpu_req;
  assign lookup      = (state == LOOKUP);
  assign wb_active   = (state == WRITEBACK);
  assign fill_active = (state == REFILL);

  // Tag written with the last refill word
  assign install = fill_active && burst_done;

  // Hit in LOOKUP updates LRU and commits a store
  assign touch        = lookup && hit;
  assign cpu_write_en = lookup && hit;

  assign cpu_ack = (state == DONE);

endmodule

// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 16
`define LINE_WORDS 4

// Address split of a 32 bit byte address
`define INDEX_W  4
`define OFFSET_W 2
`define TAG_W    24  // 32 minus index, offset and byte bits

`endif

// ==== data_store.sv ====
`include "cache_params.svh"

module data_store
  import cache_addr_pkg::*;
(
  input  logic                 clk,
  input  logic [`INDEX_W-1:0]  index,
  input  way_t                 way,
  input  logic [`OFFSET_W-1:0] offset,
  input  logic [31:0]          wdata,
  input  logic [3:0]           be,
  input  logic                 cpu_we,
  input  logic                 fill_we,
  input  logic [31:0]          fill_data,
  output logic [31:0]          rdata
);

  localparam int DEPTH = `CACHE_SETS * `LINE_WORDS;

  // One word array per way, addressed by set and word offset
  logic [31:0] mem [`CACHE_WAYS][DEPTH];

  logic [`INDEX_W+`OFFSET_W-1:0] word_addr;

  assign word_addr = {index, offset};

  always_ff @(posedge clk)
  begin
    if (fill_we)
      mem[way][word_addr] <= fill_data;  // Whole word from refill
    else if (cpu_we)
    begin
      for (int b = 0; b < 4; b++)
        if (be[b])
          mem[way][word_addr][8*b +: 8] <= wdata[8*b +: 8];
    end
  end

  // CPU read data and write-back word share this port
  assign rdata = mem[way][word_addr];

endmodule

// ==== dcache_assert.sv ====
`include "cache_params.svh"

module dcache_assert
  import cache_bus_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    cpu_req,
  input logic    cpu_ack,
  input mem_rd_t mem_rd,
  input mem_wr_t mem_wr
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LOW_W = `OFFSET_W + 2;

  ack_follows_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_ack) |-> cpu_req)
    else $error("cpu_ack rose without cpu_req");

  one_burst_at_a_time: assert property (@(posedge clk) disable iff (rst)
    !(mem_rd.rd_req && mem_wr.wr_req))
    else $error("rd_req and wr_req high together");

  // Line addresses carry no word or byte offset
  rd_line_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_rd.rd_req |-> (mem_rd.addr[LOW_W-1:0] == '0))
    else $error("read burst address not line aligned");

  wr_line_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_wr.wr_req |-> (mem_wr.addr[LOW_W-1:0] == '0))
    else $error("write burst address not line aligned");

endmodule

bind dcache_top dcache_assert u_assert (.*);

// ==== dcache_tests.txt ====
// op addr wdata be expected_rdata
// op: 0 read miss, 1 write, 2 read hit, 3 expect write-back of line addr on next op, ff end
0 00000100 00000000 0 5a5a0040
2 00000108 00000000 0 5a5a0042
1 00000104 a1b2c3d4 5 00000000
2 00000104 00000000 0 5ab200d4
0 00000200 00000000 0 5a5a0080
0 00000300 00000000 0 5a5a00c0
0 00000400 00000000 0 5a5a0100
2 00000100 00000000 0 5a5a0040
1 00000208 11223344 f 00000000
2 00000300 00000000 0 5a5a00c0
2 00000400 00000000 0 5a5a0100
2 00000100 00000000 0 5a5a0040
3 00000200 00000000 0 00000000
0 00000500 00000000 0 5a5a0140
0 00000208 00000000 0 11223344
1 0000010c deadbeef c 00000000
0 00000600 00000000 0 5a5a0180
0 00000700 00000000 0 5a5a01c0
0 00000800 00000000 0 5a5a0200
3 00000100 00000000 0 00000000
0 00000900 00000000 0 5a5a0240
0 00000104 00000000 0 5ab200d4
2 0000010c 00000000 0 dead0043
ff 00000000 00000000 0 00000000

// ==== dcache_top.sv ====
`include "cache_params.svh"

module dcache_top
  import cache_addr_pkg::*, cache_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cpu_req,
  input  cpu_req_t    cpu_in,
  output logic        cpu_ack,
  output cpu_rsp_t    cpu_out,
  output mem_rd_t     mem_rd,
  input  logic        rdata_ok,
  input  logic [31:0] rdata,
  output mem_wr_t     mem_wr,
  input  logic        wdata_ok
);

  cpu_req_t req_q;

  logic latch_req, lookup, wb_active, fill_active;
  logic install, touch, cpu_write_en, write_hit;
  logic hit, victim_dirty;
  way_t hit_way, victim_way;
  logic [`TAG_W-1:0] victim_tag;

  logic [`OFFSET_W-1:0] burst_offset, store_offset;
  logic                 burst_step, burst_done, in_burst;
  way_t                 store_way;
  logic [31:0]          store_rdata;
  addr_u                fill_addr, wb_addr;

  // Request held for the whole transaction
  always_ff @(posedge clk)
  begin
    if (latch_req)
      req_q <= cpu_in;
  end

  assign write_hit  = cpu_write_en && req_q.write;
  assign in_burst   = wb_active || fill_active;
  assign burst_step = (wb_active && wdata_ok) || (fill_active && rdata_ok);

  // Bursts use the victim way, CPU accesses the hit way
  assign store_way    = in_burst ? victim_way : hit_way;
  assign store_offset = in_burst ? burst_offset : req_q.addr.f.offset;

  ///////////////////////////////////////////////////////////////////////
  // Memory side line addresses
  ///////////////////////////////////////////////////////////////////////

  always_comb
  begin
    fill_addr            = req_q.addr;
    fill_addr.f.offset   = '0;
    fill_addr.f.byte_off = '0;
    wb_addr              = fill_addr;
    wb_addr.f.tag        = victim_tag;
  end

  assign mem_rd.addr   = fill_addr.raw;
  assign mem_rd.rd_req = fill_active;
  assign mem_wr.addr   = wb_addr.raw;
  assign mem_wr.wdata  = store_rdata;
  assign mem_wr.wr_req = wb_active;

  assign cpu_out.rdata = store_rdata;

  cache_ctrl_fsm u_fsm (
    .clk(clk), .rst(rst), .cpu_req(cpu_req), .hit(hit),
    .victim_dirty(victim_dirty), .burst_done(burst_done),
    .latch_req(latch_req), .lookup(lookup), .wb_active(wb_active),
    .fill_active(fill_active), .install(install), .touch(touch),
    .cpu_write_en(cpu_write_en), .cpu_ack(cpu_ack)
  );

  burst_counter u_burst (
    .clk(clk), .rst(rst), .start(lookup), .step(burst_step),
    .offset(burst_offset), .done(burst_done)
  );

  tag_store u_tags (
    .clk(clk), .rst(rst), .index(req_q.addr.f.index), .tag(req_q.addr.f.tag),
    .lookup(lookup), .install(install), .touch(touch), .mark_dirty(write_hit),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .victim_dirty(victim_dirty), .victim_tag(victim_tag)
  );

  data_store u_data (
    .clk(clk), .index(req_q.addr.f.index), .way(store_way), .offset(store_offset),
    .wdata(req_q.wdata), .be(req_q.be), .cpu_we(write_hit),
    .fill_we(fill_active && rdata_ok), .fill_data(rdata), .rdata(store_rdata)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and search the log for the pass line
verilator --binary --timing --assert --top-module tb_dcache -f verilog.f -o tb_dcache \
  > build.log 2>&1 \
  && ./obj_dir/tb_dcache > sim.log 2>&1 \
  ; grep -q "^TESTS PASSED$" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== tag_store.sv ====
`include "cache_params.svh"

module tag_store
  import cache_addr_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [`INDEX_W-1:0] index,
  input  logic [`TAG_W-1:0]   tag,
  input  logic                lookup,
  input  logic                install,
  input  logic                touch,
  input  logic                mark_dirty,
  output logic                hit,
  output way_t                hit_way,
  output way_t                victim_way,
  output logic                victim_dirty,
  output logic [`TAG_W-1:0]   victim_tag
);

  logic [`TAG_W-1:0]     tags [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid [`CACHE_WAYS];
  logic [`CACHE_SETS-1:0] dirty [`CACHE_WAYS];
  age_t                  ages [`CACHE_WAYS][`CACHE_SETS];

  logic [`CACHE_WAYS-1:0] match;
  logic [`CACHE_WAYS-1:0] set_valid;
  age_t                   set_age [`CACHE_WAYS];

  ///////////////////////////////////////////////////////////////////////
  // Lookup of the addressed set
  ///////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      set_valid[w] = valid[w][index];
      set_age[w]   = ages[w][index];
      match[w]     = set_valid[w] && (tags[w][index] == tag);
    end
  end

  assign hit = lookup && (|match);

  always_comb
  begin
    hit_way = '0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--)
      if (match[w])
        hit_way = way_t'(w);
  end

  // First invalid way, else oldest with low way winning ties
  always_comb
  begin
    victim_way = '0;
    if (~&set_valid)
    begin
      for (int w = `CACHE_WAYS - 1; w >= 0; w--)
        if (!set_valid[w])
          victim_way = way_t'(w);
    end
    else
    begin
      for (int w = 1; w < `CACHE_WAYS; w++)
        if (set_age[w] > set_age[victim_way])
          victim_way = way_t'(w);
    end
  end

  assign victim_dirty = set_valid[victim_way] && dirty[victim_way][index];
  assign victim_tag   = tags[victim_way][index];

  ///////////////////////////////////////////////////////////////////////
  // Updates
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (install)
      tags[victim_way][index] <= tag;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < `CACHE_WAYS; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
        for (int s = 0; s < `CACHE_SETS; s++)
          ages[w][s] <= '0;
      end
    end
    else
    begin
      if (install)
      begin
        valid[victim_way][index] <= 1'b1;
        dirty[victim_way][index] <= 1'b0;
        // New line counts as oldest until its first touch
        ages[victim_way][index] <= '1;
      end
      if (touch)
      begin
        for (int w = 0; w < `CACHE_WAYS; w++)
          if (way_t'(w) == hit_way)
            ages[w][index] <= '0;
          else if (set_age[w] < set_age[hit_way])
            ages[w][index] <= set_age[w] + 1'b1;
      end
      if (mark_dirty)
        dirty[hit_way][index] <= 1'b1;
    end
  end

endmodule

// ==== tb_dcache.sv ====
`include "cache_params.svh"

module tb_dcache
  import cache_addr_pkg::*, cache_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 4096;
  localparam int MAX_OPS   = 64;
  localparam int TIMEOUT   = 500;

  logic        clk = 1'b0;
  logic        rst;
  logic        cpu_req;
  cpu_req_t    cpu_in;
  logic        cpu_ack;
  cpu_rsp_t    cpu_out;
  mem_rd_t     mem_rd;
  logic        rdata_ok = 1'b0;
  logic [31:0] rdata = '0;
  mem_wr_t     mem_wr;
  logic        wdata_ok = 1'b0;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] shadow [MEM_WORDS];
  logic [31:0] tvec [5*MAX_OPS];

  integer seed = 32'h890f22c5;
  int     mismatch_errs = 0;
  int     other_errs = 0;
  int     rd_bursts = 0;
  int     wb_bursts = 0;
  int     rd_cnt, wr_cnt, rd_gap, wr_gap;
  logic   wb_expect = 1'b0;
  logic   timed_out = 1'b0;
  logic [31:0] wb_exp_addr;

  always #4 clk = ~clk;

  dcache_top dut0 (.*);

  function automatic int widx(input logic [31:0] byte_addr);
    return int'(byte_addr[13:2]);
  endfunction

  task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp);
    if (got !== exp)
    begin
      $display("mismatch cpu_out.rdata got %h exp %h", got.rdata, exp.rdata);
      mismatch_errs++;
    end
  endtask

  task automatic check_wr(input mem_wr_t got, input mem_wr_t exp);
    if (got !== exp)
    begin
      $display("mismatch mem_wr got %h exp %h", got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    other_errs++;
    timed_out = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Memory model with random gaps before each data_ok
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic rd_end;
    logic wr_end;
    mem_wr_t exp_wr;
    rd_end = 1'b0;
    wr_end = 1'b0;
    if (rst)
    begin
      rdata_ok <= 1'b0;
      wdata_ok <= 1'b0;
      rd_cnt = 0;
      wr_cnt = 0;
      rd_gap = -1;
      wr_gap = -1;
    end
    else
    begin
      if (rdata_ok)
      begin
        if (rd_cnt == 0)
          rd_bursts++;
        rd_cnt++;
        if (rd_cnt == `LINE_WORDS)
        begin
          rd_cnt = 0;
          rd_end = 1'b1;
        end
      end
      if (wdata_ok)
      begin
        if (!wb_expect)
        begin
          $display("unexpected write-back burst to line %h", mem_wr.addr);
          other_errs++;
        end
        else
        begin
          exp_wr.addr   = wb_exp_addr;
          exp_wr.wdata  = shadow[widx(wb_exp_addr) + wr_cnt];
          exp_wr.wr_req = 1'b1;
          check_wr(mem_wr, exp_wr);
        end
        mem[widx(mem_wr.addr) + wr_cnt] = mem_wr.wdata;
        wr_cnt++;
        if (wr_cnt == `LINE_WORDS)
        begin
          wr_cnt = 0;
          wr_end = 1'b1;
          wb_bursts++;
        end
      end
      rdata_ok <= 1'b0;
      if (mem_rd.rd_req && !rd_end)
      begin
        if (rd_gap < 0)
          rd_gap = $unsigned($random(seed)) % 3;
        if (rd_gap == 0)
        begin
          rdata_ok <= 1'b1;
          rdata    <= mem[widx(mem_rd.addr) + rd_cnt];
          rd_gap = -1;
        end
        else
          rd_gap--;
      end
      wdata_ok <= 1'b0;
      if (mem_wr.wr_req && !wr_end)
      begin
        if (wr_gap < 0)
          wr_gap = $unsigned($random(seed)) % 3;
        if (wr_gap == 0)
        begin
          wdata_ok <= 1'b1;
          wr_gap = -1;
        end
        else
          wr_gap--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////////////////////////////////////

  task automatic run_op(input logic [31:0] op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] be,
                        input logic [31:0] exp_data);
    cpu_req_t req;
    cpu_rsp_t exp_rsp;
    int       n;
    int       bursts_before;
    int       wb_before;
    req.addr.raw  = addr;
    req.write     = (op == 32'h1);
    req.wdata     = wdata;
    req.be        = be;
    exp_rsp.rdata = exp_data;
    bursts_before = rd_bursts;
    wb_before     = wb_bursts;
    @(posedge clk);
    cpu_req <= 1'b1;
    cpu_in  <= req;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
      begin
        report_timeout("cpu_ack high");
        return;
      end
    end
    while (!cpu_ack);
    if (!req.write)
      check_rsp(cpu_out, exp_rsp);
    else
      for (int b = 0; b < 4; b++)
        if (be[b])
          shadow[widx(addr)][8*b +: 8] = wdata[8*b +: 8];
    if (op == 32'h0 && rd_bursts - bursts_before != 1)
    begin
      $display("read miss at %h gave %0d refills instead of one", addr,
               rd_bursts - bursts_before);
      other_errs++;
    end
    if (op == 32'h2 && rd_bursts != bursts_before)
    begin
      $display("read at %h should hit but started a refill", addr);
      other_errs++;
    end
    if (wb_expect && wb_bursts == wb_before)
    begin
      $display("expected write-back of line %h did not happen", wb_exp_addr);
      other_errs++;
    end
    wb_expect = 1'b0;
    @(posedge clk);
    cpu_req <= 1'b0;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
      begin
        report_timeout("cpu_ack low");
        return;
      end
    end
    while (cpu_ack);
  endtask

  initial
  begin
    rst      = 1'b1;
    cpu_req  = 1'b0;
    cpu_in   = '0;
    for (int a = 0; a < MEM_WORDS; a++)
    begin
      mem[a]    = a ^ 32'h5a5a0000;
      shadow[a] = a ^ 32'h5a5a0000;
    end
    for (int i = 0; i < 5*MAX_OPS; i++)
      tvec[i] = 32'hff;
    $readmemh("dcache_tests.txt", tvec);
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (cpu_ack || mem_rd.rd_req || mem_wr.wr_req)
    begin
      $display("handshake outputs not low after reset");
      other_errs++;
    end
    for (int i = 0; i < MAX_OPS && tvec[5*i] != 32'hff && !timed_out; i++)
    begin
      if (tvec[5*i] == 32'h3)
      begin
        wb_expect   = 1'b1;
        wb_exp_addr = tvec[5*i+1];
      end
      else
        run_op(tvec[5*i], tvec[5*i+1], tvec[5*i+2], tvec[5*i+3][3:0], tvec[5*i+4]);
    end
    $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
cache_addr_pkg.sv
cache_bus_pkg.sv
burst_counter.sv
cache_ctrl_fsm.sv
tag_store.sv
data_store.sv
dcache_top.sv
dcache_assert.sv
tb_dcache.sv
